/* verif/cbus_patterns.txt */
// port rw addr len size strobe seed par stall, all hex, len is beats minus one
// par 1 runs the line together with the next one, stall 1 turns on AXI stalls
1 1 00000100 0 2 5 11223344 0 0
1 0 00000100 0 2 0 00000000 0 0
1 1 00000200 7 2 f a0000000 0 0
1 0 0000020c 7 2 0 00000000 0 0
0 1 00000304 3 2 3 5b5b0000 0 0
1 1 00000308 1 2 c c3c30010 0 0
0 0 00000300 3 2 0 00000000 0 0
0 0 00000208 3 2 0 00000000 1 0
1 1 00000380 3 2 f 77770000 0 0
0 0 00000380 3 2 0 00000000 1 0
1 0 00000040 f 2 0 00000000 0 0
1 1 000001f8 7 2 9 12340000 1 1
0 0 000000c4 7 2 0 00000000 0 1
1 0 000001e4 7 2 0 00000000 0 1
0 1 00000010 3 2 f 0f0f0000 1 1
1 0 00000388 3 2 0 00000000 0 1
0 0 00000014 3 2 0 00000000 0 1
1 0 00000204 7 2 0 00000000 0 1

/* all.f */
hdl/cbus_pkg.sv
hdl/cbus_arbiter.sv
hdl/cbus_to_axi.sv
hdl/cbus_axi_top.sv
verif/axi_mem_model.sv
verif/tb_cbus_axi.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cbus_axi -f all.f -o vtb_cbus_axi || exit 1
out=$(./obj_dir/vtb_cbus_axi)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

/* verif/tb_cbus_axi.sv */
`timescale 1ns/1ps

module tb_cbus_axi;
    import cbus_pkg::*;

    localparam int NCOL    = 9;      // columns per pattern line.
    localparam int MAX_PAT = 64;
    localparam msize_t WORD_SIZE = 3'd2;    // four bytes per beat.

    logic       aclk = 1'b0;
    logic       aresetn;
    logic       stall_en;
    cbus_req_t  req  [NUM_CBUS_PORTS];
    cbus_resp_t resp [NUM_CBUS_PORTS];

    axi_id_t    arid, rid, awid, wid, bid;
    addr_t      araddr, awaddr;
    mlen_t      arlen, awlen;
    msize_t     arsize, awsize;
    axi_burst_t arburst, awburst;
    axi_lock_t  arlock, awlock;
    axi_cache_t arcache, awcache;
    axi_prot_t  arprot, awprot;
    axi_resp_t  rresp, bresp;
    word_t      rdata, wdata;
    strobe_t    wstrb;
    logic       arvalid, arready, rlast, rvalid, rready, awvalid, awready;
    logic       wlast, wvalid, wready, bvalid, bready;

    logic [31:0] pat [NCOL*MAX_PAT];
    word_t       shadow [256];      // expected memory contents.
    int          npat = 0;
    int          errors = 0;
    int          checks = 0;
    int          good_pats = 0;

    cbus_axi_top UUT (
        .*,
        .icreq  (req[0]),
        .icresp (resp[0]),
        .dcreq  (req[1]),
        .dcresp (resp[1])
    );

    axi_mem_model u_mem (.*);

    always #50 aclk = ~aclk;

    function automatic word_t fill_word(int idx);
        addr_t b;
        b = addr_t'(idx) << 2;
        return {~b[15:0], b[15:0]};
    endfunction

    // beat k of a wrap burst, block is beats times four bytes.
    function automatic addr_t wrap_addr(addr_t first, mlen_t len, int k);
        addr_t block;
        addr_t base;
        block = (addr_t'(len) + 1) * 4;
        base  = first & ~(block - 1);
        return base + ((first - base + addr_t'(k) * 4) % block);
    endfunction

    task automatic merge_shadow(input addr_t a, input word_t d, input strobe_t s);
        for (int j = 0; j < 4; j++) begin
            if (s[j]) begin
                shadow[a[9:2]][8*j +: 8] = d[8*j +: 8];
            end
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act,
                              inout int fails);
        checks++;
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            fails++;
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act,
                              inout int fails);
        checks++;
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            fails++;
        end
    endtask

    task automatic check_burst(input string name, input axi_burst_t exp,
                               input axi_burst_t act, inout int fails);
        checks++;
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            fails++;
        end
    endtask

    task automatic check_size(input string name, input msize_t exp, input msize_t act,
                              inout int fails);
        checks++;
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            fails++;
        end
    endtask

    // one cache-bus transaction, driven and checked beat by beat.
    task automatic run_pattern(input int n, inout int fails);
        int      p;
        logic    wr;
        addr_t   addr;
        mlen_t   len;
        strobe_t strb;
        word_t   seed;
        addr_t   a;
        int      k;
        logic    done;
        p    = int'(pat[n*NCOL]);
        wr   = pat[n*NCOL+1][0];
        addr = pat[n*NCOL+2];
        len  = mlen_t'(pat[n*NCOL+3]);
        strb = strobe_t'(pat[n*NCOL+5]);
        seed = pat[n*NCOL+6];
        k    = 0;
        done = 1'b0;
        @(negedge aclk);
        req[p].valid    = 1'b1;
        req[p].is_write = wr;
        req[p].size     = msize_t'(pat[n*NCOL+4]);
        req[p].addr     = addr;
        req[p].strobe   = strb;
        req[p].data     = seed;
        req[p].len      = len;
        while (!done) begin
            @(negedge aclk);
            req[p].data = seed + word_t'(k);    // next word after each ready.
            if (resp[p].ready) begin
                a = wrap_addr(addr, len, k);
                if (wr) begin
                    merge_shadow(a, req[p].data, strb);
                end else begin
                    check_word($sformatf("port%0d.data", p), shadow[a[9:2]],
                               resp[p].data, fails);
                end
                check_last($sformatf("port%0d.last", p), k == int'(len),
                           resp[p].last, fails);
                done = resp[p].last || (k == int'(len));
                k++;
            end
        end
        @(negedge aclk);
        req[p].valid = 1'b0;
        if (fails == 0) begin
            good_pats++;
        end
        $display("pattern %0d: port %0d %s at %h, %0d beats, %0d errors",
                 n, p, wr ? "write" : "read", addr, k, fails);
    endtask

    // only one port may be served at a time.
    always @(negedge aclk) begin
        if (!aresetn) begin
            if (resp[0].ready && resp[1].ready) begin
                $display("both ports saw ready in the same cycle at %0t", $time);
                errors++;
            end
            for (int p = 0; p < NUM_CBUS_PORTS; p++) begin
                if (resp[p].ready && !req[p].valid) begin
                    $display("port %0d saw ready without a request at %0t", p, $time);
                    errors++;
                end
            end
            // address phases carry wrap bursts of whole words and zero side-band fields.
            if (arvalid) begin
                check_burst("arburst", AXI_BURST_WRAP, arburst, errors);
                check_size("arsize", WORD_SIZE, arsize, errors);
                check_word("arid arlock arcache arprot", '0,
                           word_t'({arid, arlock, arcache, arprot}), errors);
            end
            if (awvalid) begin
                check_burst("awburst", AXI_BURST_WRAP, awburst, errors);
                check_size("awsize", WORD_SIZE, awsize, errors);
                check_word("awid awlock awcache awprot", '0,
                           word_t'({awid, awlock, awcache, awprot}), errors);
            end
            if (wvalid) begin
                check_word("wid", '0, word_t'(wid), errors);
            end
        end
    end

    initial begin : watchdog
        wait (npat > 0);
        #((npat * 200 + 16) * 100);
        $display("run timed out after %0d cycles", npat * 200 + 16);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int i;
        int f0;
        int f1;
        aresetn  = 1'b1;
        stall_en = 1'b0;
        req[0]   = '0;
        req[1]   = '0;
        void'($urandom(84792));
        for (int j = 0; j < NCOL * MAX_PAT; j++) begin
            pat[j] = '1;
        end
        $readmemh("verif/cbus_patterns.txt", pat);
        while (npat < MAX_PAT && pat[npat*NCOL] != '1) begin
            npat++;
        end
        if (npat == 0) begin
            $display("no patterns were loaded from the pattern file");
            errors++;
        end
        for (int j = 0; j < 256; j++) begin
            shadow[j] = fill_word(j);
        end
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b0;
        i = 0;
        while (i < npat) begin
            stall_en = pat[i*NCOL+8][0];
            f0 = 0;
            f1 = 0;
            if (pat[i*NCOL+7][0] && i + 1 < npat) begin
                fork
                    run_pattern(i, f0);
                    run_pattern(i + 1, f1);
                join
                i += 2;
            end else begin
                run_pattern(i, f0);
                i += 1;
            end
            errors += f0 + f1;
        end
        $display("patterns %0d, clean %0d, checks %0d, errors %0d",
                 npat, good_pats, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 stall_en,      // random ready/valid gaps when high.

    input  cbus_pkg::addr_t      araddr,
    input  cbus_pkg::mlen_t      arlen,
    input  logic                 arvalid,
    output logic                 arready,
    output cbus_pkg::axi_id_t    rid,
    output cbus_pkg::word_t      rdata,
    output cbus_pkg::axi_resp_t  rresp,
    output logic                 rlast,
    output logic                 rvalid,
    input  logic                 rready,
    input  cbus_pkg::addr_t      awaddr,
    input  cbus_pkg::mlen_t      awlen,
    input  logic                 awvalid,
    output logic                 awready,
    input  cbus_pkg::word_t      wdata,
    input  cbus_pkg::strobe_t    wstrb,
    input  logic                 wlast,
    input  logic                 wvalid,
    output logic                 wready,
    output cbus_pkg::axi_id_t    bid,
    output cbus_pkg::axi_resp_t  bresp,
    output logic                 bvalid,
    input  logic                 bready
);
    import cbus_pkg::*;

    typedef enum logic [1:0] {M_IDLE, M_READ, M_WRITE, M_RESP} mstate_t;

    mstate_t state;
    word_t   mem [256];     // 1 KiB.
    addr_t   start;         // first address of the burst.
    mlen_t   blen;
    mlen_t   cnt;           // beats done so far.
    addr_t   cur;

    function automatic logic go();
        return !stall_en || (($urandom % 4) != 0);
    endfunction

    // byte address in the low half, its complement in the high half.
    function automatic word_t fill_word(int idx);
        addr_t b;
        b = addr_t'(idx) << 2;
        return {~b[15:0], b[15:0]};
    endfunction

    // wrap inside the aligned block of the whole burst.
    always_comb begin
        addr_t block;
        block = (addr_t'(blen) + 1) << 2;
        cur   = (start & ~(block - 1)) | ((start + (addr_t'(cnt) << 2)) & (block - 1));
    end

    assign rdata = mem[cur[9:2]];
    assign rlast = cnt == blen;
    assign rid   = '0;
    assign rresp = '0;
    assign bid   = '0;
    assign bresp = '0;

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            state   <= M_IDLE;
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            cnt     <= '0;
            blen    <= '0;
            start   <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(i);
            end
        end else begin
            case (state)
                M_IDLE: begin
                    if (arvalid && arready) begin
                        arready <= 1'b0;
                        start   <= araddr;
                        blen    <= arlen;
                        cnt     <= '0;
                        state   <= M_READ;
                    end else if (awvalid && awready) begin
                        awready <= 1'b0;
                        start   <= awaddr;
                        blen    <= awlen;
                        cnt     <= '0;
                        state   <= M_WRITE;
                    end else if (arvalid) begin
                        arready <= go();
                    end else if (awvalid) begin
                        awready <= go();
                    end
                end
                M_READ: begin
                    if (rvalid && rready) begin
                        if (rlast) begin
                            rvalid <= 1'b0;
                            state  <= M_IDLE;
                        end else begin
                            cnt    <= cnt + mlen_t'(1);
                            rvalid <= go();
                        end
                    end else if (!rvalid) begin
                        rvalid <= go();
                    end
                end
                M_WRITE: begin
                    if (wvalid && wready) begin
                        for (int j = 0; j < 4; j++) begin
                            if (wstrb[j]) begin
                                mem[cur[9:2]][8*j +: 8] <= wdata[8*j +: 8];
                            end
                        end
                        if (wlast) begin
                            wready <= 1'b0;
                            state  <= M_RESP;
                        end else begin
                            cnt    <= cnt + mlen_t'(1);
                            wready <= go();
                        end
                    end else if (wvalid) begin
                        wready <= go();
                    end
                end
                default: begin
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state  <= M_IDLE;
                    end else if (!bvalid) begin
                        bvalid <= go();
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/cbus_axi_top.sv */
`timescale 1ns/1ps

module cbus_axi_top (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  cbus_pkg::cbus_req_t  icreq,
    output cbus_pkg::cbus_resp_t icresp,
    input  cbus_pkg::cbus_req_t  dcreq,
    output cbus_pkg::cbus_resp_t dcresp,

    output cbus_pkg::axi_id_t    arid,
    output cbus_pkg::addr_t      araddr,
    output cbus_pkg::mlen_t      arlen,
    output cbus_pkg::msize_t     arsize,
    output cbus_pkg::axi_burst_t arburst,
    output cbus_pkg::axi_lock_t  arlock,
    output cbus_pkg::axi_cache_t arcache,
    output cbus_pkg::axi_prot_t  arprot,
    output logic                 arvalid,
    input  logic                 arready,
    input  cbus_pkg::axi_id_t    rid,
    input  cbus_pkg::word_t      rdata,
    input  cbus_pkg::axi_resp_t  rresp,
    input  logic                 rlast,
    input  logic                 rvalid,
    output logic                 rready,
    output cbus_pkg::axi_id_t    awid,
    output cbus_pkg::addr_t      awaddr,
    output cbus_pkg::mlen_t      awlen,
    output cbus_pkg::msize_t     awsize,
    output cbus_pkg::axi_burst_t awburst,
    output cbus_pkg::axi_lock_t  awlock,
    output cbus_pkg::axi_cache_t awcache,
    output cbus_pkg::axi_prot_t  awprot,
    output logic                 awvalid,
    input  logic                 awready,
    output cbus_pkg::axi_id_t    wid,
    output cbus_pkg::word_t      wdata,
    output cbus_pkg::strobe_t    wstrb,
    output logic                 wlast,
    output logic                 wvalid,
    input  logic                 wready,
    input  cbus_pkg::axi_id_t    bid,
    input  cbus_pkg::axi_resp_t  bresp,
    input  logic                 bvalid,
    output logic                 bready
);
    import cbus_pkg::*;

    cbus_req_t  creqs  [NUM_CBUS_PORTS];
    cbus_resp_t cresps [NUM_CBUS_PORTS];
    cbus_req_t  mreq;      // granted request into the bridge.
    cbus_resp_t mresp;
    logic       idle;

    // port 0 is the instruction cache.
    assign creqs[0] = icreq;
    assign creqs[1] = dcreq;
    assign icresp   = cresps[0];
    assign dcresp   = cresps[1];

    cbus_arbiter u_arbiter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .creqs   (creqs),
        .cresps  (cresps),
        .mreq    (mreq),
        .mresp   (mresp),
        .idle    (idle)
    );

    // axi ports share names with the top.
    cbus_to_axi u_bridge (
        .*,
        .creq  (mreq),
        .cresp (mresp),
        .idle  (idle)
    );

endmodule

/* hdl/cbus_to_axi.sv */
`timescale 1ns/1ps

module cbus_to_axi (
    input  logic                 aclk,
    input  logic                 aresetn,

    output cbus_pkg::axi_id_t    arid,
    output cbus_pkg::addr_t      araddr,
    output cbus_pkg::mlen_t      arlen,
    output cbus_pkg::msize_t     arsize,
    output cbus_pkg::axi_burst_t arburst,
    output cbus_pkg::axi_lock_t  arlock,
    output cbus_pkg::axi_cache_t arcache,
    output cbus_pkg::axi_prot_t  arprot,
    output logic                 arvalid,
    input  logic                 arready,
    input  cbus_pkg::axi_id_t    rid,
    input  cbus_pkg::word_t      rdata,
    input  cbus_pkg::axi_resp_t  rresp,
    input  logic                 rlast,
    input  logic                 rvalid,
    output logic                 rready,
    output cbus_pkg::axi_id_t    awid,
    output cbus_pkg::addr_t      awaddr,
    output cbus_pkg::mlen_t      awlen,
    output cbus_pkg::msize_t     awsize,
    output cbus_pkg::axi_burst_t awburst,
    output cbus_pkg::axi_lock_t  awlock,
    output cbus_pkg::axi_cache_t awcache,
    output cbus_pkg::axi_prot_t  awprot,
    output logic                 awvalid,
    input  logic                 awready,
    output cbus_pkg::axi_id_t    wid,
    output cbus_pkg::word_t      wdata,
    output cbus_pkg::strobe_t    wstrb,
    output logic                 wlast,
    output logic                 wvalid,
    input  logic                 wready,
    input  cbus_pkg::axi_id_t    bid,
    input  cbus_pkg::axi_resp_t  bresp,
    input  logic                 bvalid,
    output logic                 bready,

    input  cbus_pkg::cbus_req_t  creq,
    output cbus_pkg::cbus_resp_t cresp,
    output logic                 idle
);
    import cbus_pkg::*;

    pend_t     pending;       // channels still owed a handshake.
    pend_t     done;          // channels that finish this cycle.
    cbus_req_t saved_req;     // request captured at start, len counts down.
    logic      busy;
    logic      is_last;       // current beat is the final one.
    logic      r_beat;
    logic      w_beat;

    assign busy    = |pending;
    assign idle    = !busy;
    assign is_last = saved_req.len == '0;

    assign r_beat = pending[CH_R] && rvalid;
    assign w_beat = pending[CH_W] && wready;

    // data channels finish only on their final beat.
    assign done[CH_AR] = pending[CH_AR] && arready;
    assign done[CH_R]  = r_beat && is_last;
    assign done[CH_AW] = pending[CH_AW] && awready;
    assign done[CH_W]  = w_beat && is_last;
    assign done[CH_B]  = pending[CH_B] && bvalid;

    // read beats go straight through to the cache.
    assign cresp.ready = r_beat || w_beat;
    assign cresp.last  = cresp.ready && is_last;
    assign cresp.data  = rdata;

    // read address channel.
    assign arid    = '0;
    assign araddr  = saved_req.addr;
    assign arlen   = saved_req.len;
    assign arsize  = saved_req.size;
    assign arburst = AXI_BURST_WRAP;
    assign arlock  = '0;
    assign arcache = '0;
    assign arprot  = '0;
    assign arvalid = pending[CH_AR];
    assign rready  = pending[CH_R];

    // write address channel.
    assign awid    = '0;
    assign awaddr  = saved_req.addr;
    assign awlen   = saved_req.len;
    assign awsize  = saved_req.size;
    assign awburst = AXI_BURST_WRAP;
    assign awlock  = '0;
    assign awcache = '0;
    assign awprot  = '0;
    assign awvalid = pending[CH_AW];

    // requester moves to the next word after each ready.
    assign wid    = '0;
    assign wdata  = creq.data;
    assign wstrb  = creq.strobe;
    assign wlast  = is_last;
    assign wvalid = pending[CH_W];
    assign bready = pending[CH_B];

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            pending <= '0;
        end else if (busy) begin
            pending <= pending & ~done;
        end else if (creq.valid) begin
            pending <= creq.is_write ? PEND_WRITE : PEND_READ;
        end
    end

    always_ff @(posedge aclk) begin
        if (!busy) begin
            saved_req <= creq;                          // sampled every idle cycle.
        end else if (cresp.ready && !cresp.last) begin
            saved_req.len <= saved_req.len - mlen_t'(1);
        end
    end

    // slave burst length must agree with the cache request.
    a_rlast_final: assert property (
        @(posedge aclk) disable iff (aresetn)
        r_beat && rlast |-> is_last
    );

    a_one_addr_phase: assert property (
        @(posedge aclk) disable iff (aresetn)
        !(awvalid && arvalid)
    );

endmodule

/* hdl/cbus_arbiter.sv */
`timescale 1ns/1ps

module cbus_arbiter (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  cbus_pkg::cbus_req_t  creqs  [cbus_pkg::NUM_CBUS_PORTS],
    output cbus_pkg::cbus_resp_t cresps [cbus_pkg::NUM_CBUS_PORTS],
    output cbus_pkg::cbus_req_t  mreq,
    input  cbus_pkg::cbus_resp_t mresp,
    input  logic                 idle
);
    import cbus_pkg::*;

    logic      locked;        // grant frozen for the running transaction.
    port_idx_t last_grant;    // winner of the most recent transaction.
    port_idx_t pick;          // round-robin choice among live requests.
    port_idx_t grant;
    logic      start;

    // search starts one past the previous winner.
    always_comb begin : rr_pick
        int   cand;
        logic found;
        pick  = last_grant;
        found = 1'b0;
        cand  = 0;
        for (int i = 1; i <= NUM_CBUS_PORTS; i++) begin
            cand = (int'(last_grant) + i) % NUM_CBUS_PORTS;
            if (!found && creqs[cand].valid) begin
                pick  = port_idx_t'(cand);
                found = 1'b1;
            end
        end
    end

    assign grant = locked ? last_grant : pick;
    assign mreq  = creqs[grant];
    assign start = !locked && idle && mreq.valid;   // bridge captures this cycle.

    // only the granted port sees the beats.
    always_comb begin
        for (int i = 0; i < NUM_CBUS_PORTS; i++) begin
            cresps[i].data  = mresp.data;
            cresps[i].ready = mresp.ready && (grant == port_idx_t'(i));
            cresps[i].last  = mresp.last && (grant == port_idx_t'(i));
        end
    end

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            locked     <= 1'b0;
            last_grant <= '0;
        end else if (locked && mresp.last) begin
            locked <= 1'b0;                         // free again after the last beat.
        end else if (start) begin
            locked     <= 1'b1;
            last_grant <= grant;
        end
    end

    // the owner keeps its request up and unchanged until last.
    a_grant_stable: assert property (
        @(posedge aclk) disable iff (aresetn)
        locked && !mresp.last |=>
            mreq.valid &&
            mreq.addr == $past(mreq.addr) &&
            mreq.is_write == $past(mreq.is_write) &&
            mreq.len == $past(mreq.len)
    );

endmodule

/* hdl/cbus_pkg.sv */
package cbus_pkg;

    // bus widths.
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int LEN_WIDTH  = 4;      // axi3 burst length field.
    localparam int SIZE_WIDTH = 3;

    // axi3 side-band widths.
    localparam int AXI_ID_WIDTH    = 4;
    localparam int AXI_LOCK_WIDTH  = 2;
    localparam int AXI_CACHE_WIDTH = 4;
    localparam int AXI_PROT_WIDTH  = 3;
    localparam int AXI_RESP_WIDTH  = 2;
    localparam int AXI_BURST_WIDTH = 2;

    // instruction port is 0, data port is 1.
    localparam int NUM_CBUS_PORTS = 2;
    localparam int PORT_WIDTH     = $clog2(NUM_CBUS_PORTS);

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [DATA_WIDTH-1:0]      word_t;
    typedef logic [STRB_WIDTH-1:0]      strobe_t;
    typedef logic [LEN_WIDTH-1:0]       mlen_t;     // beats minus one.
    typedef logic [SIZE_WIDTH-1:0]      msize_t;    // log2 of bytes per beat.
    typedef logic [PORT_WIDTH-1:0]      port_idx_t;

    typedef logic [AXI_ID_WIDTH-1:0]    axi_id_t;
    typedef logic [AXI_LOCK_WIDTH-1:0]  axi_lock_t;
    typedef logic [AXI_CACHE_WIDTH-1:0] axi_cache_t;
    typedef logic [AXI_PROT_WIDTH-1:0]  axi_prot_t;
    typedef logic [AXI_RESP_WIDTH-1:0]  axi_resp_t;
    typedef logic [AXI_BURST_WIDTH-1:0] axi_burst_t;

    localparam axi_burst_t AXI_BURST_FIXED = 2'b00;
    localparam axi_burst_t AXI_BURST_INCR  = 2'b01;
    localparam axi_burst_t AXI_BURST_WRAP  = 2'b10;

    // cache bus request, held by the requester until last.
    typedef struct packed {
        logic    valid;
        logic    is_write;
        msize_t  size;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;      // write word of the current beat.
        mlen_t   len;
    } cbus_req_t;

    // cache bus response, one ready pulse per beat.
    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    // bit positions in the bridge's pending channel set.
    localparam int CH_AR = 4;
    localparam int CH_R  = 3;
    localparam int CH_AW = 2;
    localparam int CH_W  = 1;
    localparam int CH_B  = 0;

    typedef logic [4:0] pend_t;

    localparam pend_t PEND_READ  = 5'b11000;   // ar and r.
    localparam pend_t PEND_WRITE = 5'b00111;   // aw, w and b.

endpackage
